// ==== hdl/smu_spi_pkg.sv ====
/*
  SPI link definitions for the SMU control bank
  frame sizes, raw pin bundle, synchronized events and the committed frame
  imported by the SPI stages and the top level
*/

package smu_spi_pkg;

  //////////////////////////////////////////////////
  // frame geometry

  // one frame is an address byte then a value byte, msb first
  localparam int FRAME_BITS = 16;
  localparam int ADDR_BITS  = 8;
  localparam int DATA_BITS  = 8;

  //////////////////////////////////////////////////
  // pin and event bundles

  // raw pins from the mcu, still asynchronous to clk
  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic mosi;
  } spi_pins_t;

  // single-cycle strobes in the clk domain
  // cs_start on cs_n fall, cs_end on cs_n rise
  typedef struct packed {
    logic sclk_rise;
    logic sclk_fall;
    logic cs_start;
    logic cs_end;
    logic mosi;       // synchronized level, aligned with the strobes
  } spi_events_t;

  // committed write frame, valid for one cycle
  typedef struct packed {
    logic                 valid;
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] value;  // high nibble clear bits, low nibble set bits
  } reg_frame_t;

endpackage

// ==== hdl/smu_reg_pkg.sv ====
/*
  SMU control register map
  address and command encodings, the register image and its two presets
  imported by the register file and the top level
*/

package smu_reg_pkg;

  // every control register is one nibble wide
  localparam int REG_BITS = 4;

  //////////////////////////////////////////////////
  // address map

  // register addresses plus the two command opcodes
  typedef enum logic [7:0] {
    CMD_POWERUP      = 8'd6,
    LED              = 8'd7,
    MUX              = 8'd8,
    DAC              = 8'd9,
    RAILS            = 8'd10,
    CMD_SOFT_RESET   = 8'd11,
    DAC_REF_MUX      = 8'd12,
    ADC              = 8'd14,
    MUX_POL          = 8'd15,
    MUX_SEL          = 8'd16,
    RELAY_COM        = 8'd17,
    IRANGE_X_SW      = 8'd18,
    MON_RAILS        = 8'd19,   // read only, board inputs
    RAILS_OE         = 8'd24,
    INA_VFB_SW       = 8'd25,
    INA_IFB_SW       = 8'd28,
    INA_VFB_ATTEN_SW = 8'd29,
    ISENSE_MUX       = 8'd30,
    RELAY_OUT        = 8'd31,
    IRANGE_YZ_SW     = 8'd33
  } reg_addr_e;

  //////////////////////////////////////////////////
  // register image

  // first field sits at the msb end
  typedef struct packed {
    logic [REG_BITS-1:0] led;
    logic [REG_BITS-1:0] mux;               // peripheral chip-select routing
    logic [REG_BITS-1:0] dac;
    logic [REG_BITS-1:0] rails;
    logic [REG_BITS-1:0] dac_ref_mux;
    logic [REG_BITS-1:0] adc;
    logic [REG_BITS-1:0] mux_pol;
    logic [REG_BITS-1:0] mux_sel;
    logic [REG_BITS-1:0] relay_com;
    logic [REG_BITS-1:0] irange_x_sw;
    logic [REG_BITS-1:0] rails_oe;
    logic [REG_BITS-1:0] ina_vfb_sw;
    logic [REG_BITS-1:0] ina_ifb_sw;
    logic [REG_BITS-1:0] ina_vfb_atten_sw;
    logic [REG_BITS-1:0] isense_mux;
    logic [REG_BITS-1:0] relay_out;
    logic [REG_BITS-1:0] irange_yz_sw;
  } ctrl_regs_t;

  // safe state, rails off and analog switches open
  // also the power-on state
  localparam ctrl_regs_t SOFT_RESET_REGS = '{
    mux_pol: 4'hF, mux_sel: 4'hF,         // dg444 active low, off
    rails_oe: 4'h1,                       // rail enable active low, held off
    ina_ifb_sw: 4'hF, isense_mux: 4'hF,
    ina_vfb_atten_sw: 4'h3,               // opto pair
    default: 4'h0
  };

  // rails-on preset, mux and dac are taken from the live registers instead
  localparam ctrl_regs_t POWERUP_REGS = '{
    led: 4'h0, mux: 4'h0, dac: 4'h0,
    rails: 4'h3,                          // +5V and +-15V on
    dac_ref_mux: 4'h3, adc: 4'h0,
    mux_pol: 4'hF, mux_sel: 4'hF, relay_com: 4'h0, irange_x_sw: 4'h0,
    rails_oe: 4'h0,                       // outputs driven
    ina_vfb_sw: 4'hF, ina_ifb_sw: 4'hF, ina_vfb_atten_sw: 4'h3,
    isense_mux: 4'hF, relay_out: 4'h0, irange_yz_sw: 4'h0
  };

  // answer for any address with nothing to read
  localparam logic [7:0] READ_MISS = 8'hFF;

endpackage

// ==== hdl/spi_input_sync.sv ====
/*
  SPI pin synchronizer, first stage of the control bank
  brings sclk, cs_n and mosi into the clk domain and turns edges into strobes
  strobes appear three clk cycles after the pin edge
*/

module spi_input_sync import smu_spi_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  spi_pins_t   pins,
  output spi_events_t evt
);

  // idle bus, mode 0 clock low and chip select released
  localparam spi_pins_t PINS_IDLE = '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0};

  spi_pins_t meta;    // first flop, may go metastable
  spi_pins_t sync;    // second flop, safe to use
  spi_pins_t prev;    // sync delayed by one for edge detect

  //////////////////////////////////////////////////
  // synchronizer and edge register

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      meta <= PINS_IDLE;
      sync <= PINS_IDLE;
      prev <= PINS_IDLE;
      evt  <= '0;
    end
    else
    begin
      meta <= pins;
      sync <= meta;
      prev <= sync;
      // strobes registered, keeps mosi in step with sclk_rise
      evt <= '{
        sclk_rise: sync.sclk & ~prev.sclk,
        sclk_fall: ~sync.sclk & prev.sclk,
        cs_start:  ~sync.cs_n & prev.cs_n,
        cs_end:    sync.cs_n & ~prev.cs_n,
        mosi:      sync.mosi
      };
    end
  end

endmodule

// ==== hdl/spi_frame_shifter.sv ====
/*
  SPI frame shifter, second stage of the control bank
  counts and shifts mosi bits per chip-select cycle, latches the read address
  after the first byte, shifts readback out on bank_miso, emits 16-bit frames
*/

module spi_frame_shifter import smu_spi_pkg::*; import smu_reg_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  spi_events_t          evt,
  input  logic [DATA_BITS-1:0] rd_data,
  output reg_addr_e            rd_addr,
  output reg_frame_t           frame,
  output logic                 bank_miso
);

  // room to count past 16 so long frames are caught
  localparam int CNT_BITS = $clog2(FRAME_BITS) + 1;

  logic                  active;      // between cs_start and cs_end
  logic [CNT_BITS-1:0]   bit_cnt;     // saturating
  logic [FRAME_BITS-1:0] rx_sr;
  logic [DATA_BITS-1:0]  tx_sr;
  logic                  frame_valid;
  logic                  shift_en;
  logic                  cnt_full;

  // sample only inside a frame and never on a cs edge
  assign shift_en = active & evt.sclk_rise & ~evt.cs_start & ~evt.cs_end;
  assign cnt_full = &bit_cnt;

  //////////////////////////////////////////////////
  // frame control and miso side

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      active      <= 1'b0;
      bit_cnt     <= '0;
      tx_sr       <= '1;
      bank_miso   <= 1'b1;
      frame_valid <= 1'b0;
    end
    else
    begin
      frame_valid <= 1'b0;
      if (evt.cs_start)
      begin
        active    <= 1'b1;
        bit_cnt   <= '0;
        tx_sr     <= '1;
        bank_miso <= 1'b1;
      end
      else if (evt.cs_end)
      begin
        active <= 1'b0;
        // commit only on an exact 16-bit frame
        frame_valid <= active && (bit_cnt == CNT_BITS'(FRAME_BITS));
      end
      else if (active)
      begin
        if (shift_en && !cnt_full)
          bit_cnt <= bit_cnt + CNT_BITS'(1);
        // mode 0, next bit goes out after the falling edge
        if (evt.sclk_fall)
        begin
          if (bit_cnt == CNT_BITS'(ADDR_BITS))
          begin
            // address byte done, start the readback byte
            bank_miso <= rd_data[DATA_BITS-1];
            tx_sr     <= {rd_data[DATA_BITS-2:0], 1'b1};
          end
          else
          begin
            // ones fill while the address is still coming in
            bank_miso <= tx_sr[DATA_BITS-1];
            tx_sr     <= {tx_sr[DATA_BITS-2:0], 1'b1};
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // receive shift and read address

  always_ff @(posedge clk)
  begin
    if (shift_en)
    begin
      // msb first, shift toward the top
      rx_sr <= {rx_sr[FRAME_BITS-2:0], evt.mosi};
      // eighth bit completes the address byte
      if (bit_cnt == CNT_BITS'(ADDR_BITS - 1))
        rd_addr <= reg_addr_e'({rx_sr[ADDR_BITS-2:0], evt.mosi});
    end
  end

  // rx_sr holds still after cs_end, so the frame can read it directly
  assign frame = '{
    valid: frame_valid,
    addr:  rx_sr[FRAME_BITS-1:DATA_BITS],
    value: rx_sr[DATA_BITS-1:0]
  };

endmodule

// ==== hdl/ctrl_reg_file.sv ====
/*
  Control register file, third stage of the control bank
  applies set, clear and toggle writes and the two command presets,
  and answers readback for the LED register and the rail monitors
*/

module ctrl_reg_file import smu_spi_pkg::*; import smu_reg_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  reg_frame_t           frame,
  input  reg_addr_e            rd_addr,
  input  logic [REG_BITS-1:0]  mon_rails,
  output logic [DATA_BITS-1:0] rd_data,
  output ctrl_regs_t           regs
);

  // powerup preset with the live mux and dac folded in
  ctrl_regs_t powerup_next;

  //////////////////////////////////////////////////
  // nibble update rule

  // low nibble sets, high nibble clears
  // a bit named in both nibbles toggles
  function automatic logic [REG_BITS-1:0] apply_update(
    input logic [REG_BITS-1:0]  cur,
    input logic [DATA_BITS-1:0] value
  );
    logic [REG_BITS-1:0] set_bits;
    logic [REG_BITS-1:0] clr_bits;
    logic [REG_BITS-1:0] both;
    set_bits = value[REG_BITS-1:0];
    clr_bits = value[DATA_BITS-1:REG_BITS];
    both     = set_bits & clr_bits;
    if (|both)
      return cur ^ both;
    return (cur | set_bits) & ~clr_bits;
  endfunction

  // dac is set up before the rails come on, mux stays put mid-transfer
  always_comb
  begin
    powerup_next     = POWERUP_REGS;
    powerup_next.mux = regs.mux;
    powerup_next.dac = regs.dac;
  end

  //////////////////////////////////////////////////
  // write side

  always_ff @(posedge clk)
  begin
    if (reset)
      regs <= SOFT_RESET_REGS;
    else if (frame.valid)
    begin
      case (reg_addr_e'(frame.addr))
        LED:              regs.led <= apply_update(regs.led, frame.value);
        MUX:              regs.mux <= apply_update(regs.mux, frame.value);
        DAC:              regs.dac <= apply_update(regs.dac, frame.value);
        RAILS:            regs.rails <= apply_update(regs.rails, frame.value);
        DAC_REF_MUX:      regs.dac_ref_mux <= apply_update(regs.dac_ref_mux, frame.value);
        ADC:              regs.adc <= apply_update(regs.adc, frame.value);
        MUX_POL:          regs.mux_pol <= apply_update(regs.mux_pol, frame.value);
        MUX_SEL:          regs.mux_sel <= apply_update(regs.mux_sel, frame.value);
        RELAY_COM:        regs.relay_com <= apply_update(regs.relay_com, frame.value);
        IRANGE_X_SW:      regs.irange_x_sw <= apply_update(regs.irange_x_sw, frame.value);
        RAILS_OE:         regs.rails_oe <= apply_update(regs.rails_oe, frame.value);
        INA_VFB_SW:       regs.ina_vfb_sw <= apply_update(regs.ina_vfb_sw, frame.value);
        INA_IFB_SW:       regs.ina_ifb_sw <= apply_update(regs.ina_ifb_sw, frame.value);
        INA_VFB_ATTEN_SW:
          regs.ina_vfb_atten_sw <= apply_update(regs.ina_vfb_atten_sw, frame.value);
        ISENSE_MUX:       regs.isense_mux <= apply_update(regs.isense_mux, frame.value);
        RELAY_OUT:        regs.relay_out <= apply_update(regs.relay_out, frame.value);
        IRANGE_YZ_SW:     regs.irange_yz_sw <= apply_update(regs.irange_yz_sw, frame.value);
        // commands, value byte ignored
        CMD_SOFT_RESET:   regs <= SOFT_RESET_REGS;
        CMD_POWERUP:      regs <= powerup_next;
        // mon_rails and unmapped addresses, no effect
        default:          ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // read side

  // combinational from the latched address
  always_comb
  begin
    case (rd_addr)
      LED:       rd_data = {{(DATA_BITS - REG_BITS){1'b0}}, regs.led};
      MON_RAILS: rd_data = {{(DATA_BITS - REG_BITS){1'b0}}, mon_rails};
      default:   rd_data = READ_MISS;
    endcase
  end

endmodule

// ==== hdl/periph_spi_router.sv ====
/*
  Peripheral SPI router, last stage of the control bank
  cs2_n fans out to the peripherals picked by the mux register,
  miso comes from those peripherals or from the bank itself
*/

module periph_spi_router #(
  parameter int NUM_PERIPH = 4
)
(
  input  logic                  cs2_n,
  input  logic [NUM_PERIPH-1:0] mux_sel,
  input  logic                  bank_miso,
  input  logic [NUM_PERIPH-1:0] periph_miso,
  output logic [NUM_PERIPH-1:0] periph_cs_n,
  output logic                  miso
);

  always_comb
  begin
    if (!cs2_n)
    begin
      // selected peripherals get an active-low select
      periph_cs_n = ~mux_sel;
      miso        = |(mux_sel & periph_miso);
    end
    else
    begin
      // cs2 idle, bank owns miso
      periph_cs_n = '1;
      miso        = bank_miso;
    end
  end

endmodule

// ==== hdl/smu_ctrl_top.sv ====
/*
  SMU control bank top level
  SPI register bank with set, clear and toggle writes and peripheral routing
  the register image leaves as one packed struct
*/

module smu_ctrl_top import smu_spi_pkg::*; import smu_reg_pkg::*; #(
  parameter int NUM_PERIPH = 4
)
(
  input  logic                  clk,
  input  logic                  reset,
  input  spi_pins_t             pins,
  input  logic                  cs2_n,
  input  logic [NUM_PERIPH-1:0] periph_miso,
  input  logic [REG_BITS-1:0]   mon_rails,
  output logic                  miso,
  output logic [NUM_PERIPH-1:0] periph_cs_n,
  output ctrl_regs_t            regs
);

  spi_events_t          evt;
  reg_frame_t           frame;
  reg_addr_e            rd_addr;
  logic [DATA_BITS-1:0] rd_data;
  logic                 bank_miso;

  //////////////////////////////////////////////////
  // pipeline, pins to registers

  spi_input_sync sync_i (
    .clk   (clk),
    .reset (reset),
    .pins  (pins),
    .evt   (evt)
  );

  spi_frame_shifter shifter_i (
    .clk       (clk),
    .reset     (reset),
    .evt       (evt),
    .rd_data   (rd_data),
    .rd_addr   (rd_addr),
    .frame     (frame),
    .bank_miso (bank_miso)
  );

  ctrl_reg_file reg_file_i (
    .clk       (clk),
    .reset     (reset),
    .frame     (frame),
    .rd_addr   (rd_addr),
    .mon_rails (mon_rails),
    .rd_data   (rd_data),
    .regs      (regs)
  );

  // low mux bits route the second chip select
  periph_spi_router #(.NUM_PERIPH(NUM_PERIPH)) router_i (
    .cs2_n       (cs2_n),
    .mux_sel     (regs.mux[NUM_PERIPH-1:0]),
    .bank_miso   (bank_miso),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

endmodule

// ==== verification/smu_ctrl_tb.sv ====
/*
  testbench for the SMU control bank top level
  an SPI master plays a table of frames against a register model,
  checks commit timing, readback, short and long frames and peripheral routing
*/

module smu_ctrl_tb import smu_spi_pkg::*; import smu_reg_pkg::*; ();

  localparam int NUM_PERIPH     = 4;
  localparam int IMG_BITS       = $bits(ctrl_regs_t);
  localparam int HALF_SCLK      = 8;    // clk cycles per sclk phase
  localparam int COMMIT_LATENCY = 5;    // cs_n rise at the pin to regs
  localparam int COMMIT_WINDOW  = 20;

  // one table row, stimulus plus what the model expects
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] value;
    logic [4:0] nbits;
    logic       route_cs2_n;   // cs2_n level for the routing check after the frame
    ctrl_regs_t exp_regs;
    logic [7:0] exp_read;
  } entry_t;

  logic                  clk;
  logic                  reset;
  spi_pins_t             pins;
  logic                  cs2_n;
  logic [NUM_PERIPH-1:0] periph_miso;
  logic [REG_BITS-1:0]   mon_rails;
  logic                  miso;
  logic [NUM_PERIPH-1:0] periph_cs_n;
  ctrl_regs_t            regs;

  entry_t     table_q[$];
  ctrl_regs_t model_regs;

  smu_ctrl_top #(.NUM_PERIPH(NUM_PERIPH)) dut_i (
    .clk         (clk),
    .reset       (reset),
    .pins        (pins),
    .cs2_n       (cs2_n),
    .periph_miso (periph_miso),
    .mon_rails   (mon_rails),
    .miso        (miso),
    .periph_cs_n (periph_cs_n),
    .regs        (regs)
  );

  initial
    clk = 1'b0;
  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // reference model

  // per bit, a bit in both nibbles flips the whole shared set
  function automatic logic [REG_BITS-1:0] nibble_update(
    input logic [REG_BITS-1:0] cur,
    input logic [7:0]          value
  );
    logic [REG_BITS-1:0] shared;
    logic [REG_BITS-1:0] res;
    int b;
    shared = value[3:0] & value[7:4];
    for (b = 0; b < REG_BITS; b++)
    begin
      if (shared != '0)
        res[b] = cur[b] ^ shared[b];
      else if (value[REG_BITS+b])
        res[b] = 1'b0;
      else if (value[b])
        res[b] = 1'b1;
      else
        res[b] = cur[b];
    end
    return res;
  endfunction

  function automatic ctrl_regs_t apply_frame(
    input ctrl_regs_t cur,
    input logic [7:0] addr,
    input logic [7:0] value,
    input int         nbits
  );
    ctrl_regs_t nxt;
    nxt = cur;
    // anything but 16 bits is dropped
    if (nbits != 16)
      return cur;
    case (reg_addr_e'(addr))
      LED:              nxt.led = nibble_update(cur.led, value);
      MUX:              nxt.mux = nibble_update(cur.mux, value);
      DAC:              nxt.dac = nibble_update(cur.dac, value);
      RAILS:            nxt.rails = nibble_update(cur.rails, value);
      DAC_REF_MUX:      nxt.dac_ref_mux = nibble_update(cur.dac_ref_mux, value);
      ADC:              nxt.adc = nibble_update(cur.adc, value);
      MUX_POL:          nxt.mux_pol = nibble_update(cur.mux_pol, value);
      MUX_SEL:          nxt.mux_sel = nibble_update(cur.mux_sel, value);
      RELAY_COM:        nxt.relay_com = nibble_update(cur.relay_com, value);
      IRANGE_X_SW:      nxt.irange_x_sw = nibble_update(cur.irange_x_sw, value);
      RAILS_OE:         nxt.rails_oe = nibble_update(cur.rails_oe, value);
      INA_VFB_SW:       nxt.ina_vfb_sw = nibble_update(cur.ina_vfb_sw, value);
      INA_IFB_SW:       nxt.ina_ifb_sw = nibble_update(cur.ina_ifb_sw, value);
      INA_VFB_ATTEN_SW: nxt.ina_vfb_atten_sw = nibble_update(cur.ina_vfb_atten_sw, value);
      ISENSE_MUX:       nxt.isense_mux = nibble_update(cur.isense_mux, value);
      RELAY_OUT:        nxt.relay_out = nibble_update(cur.relay_out, value);
      IRANGE_YZ_SW:     nxt.irange_yz_sw = nibble_update(cur.irange_yz_sw, value);
      CMD_SOFT_RESET:   nxt = SOFT_RESET_REGS;
      CMD_POWERUP:
      begin
        // preset, but mux and dac survive
        nxt     = POWERUP_REGS;
        nxt.mux = cur.mux;
        nxt.dac = cur.dac;
      end
      default:          nxt = cur;
    endcase
    return nxt;
  endfunction

  // byte seen on miso during the value byte
  function automatic logic [7:0] expected_read(input ctrl_regs_t cur, input logic [7:0] addr);
    case (reg_addr_e'(addr))
      LED:       return {4'h0, cur.led};
      MON_RAILS: return {4'h0, mon_rails};
      default:   return 8'hFF;
    endcase
  endfunction

  task automatic add_entry(
    input logic [7:0] addr,
    input logic [7:0] value,
    input int         nbits,
    input logic       cs2_level
  );
    entry_t e;
    e.addr        = addr;
    e.value       = value;
    e.nbits       = 5'(nbits);
    e.route_cs2_n = cs2_level;
    e.exp_read    = expected_read(model_regs, addr);
    model_regs    = apply_frame(model_regs, addr, value, nbits);
    e.exp_regs    = model_regs;
    table_q.push_back(e);
  endtask

  //////////////////////////////////////////////////
  // checks and waits

  task automatic check_equal(
    input logic [IMG_BITS-1:0] got,
    input logic [IMG_BITS-1:0] exp,
    input string               what
  );
    assert (got === exp)
    else
    begin
      $display("** Error at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic hold_cycles(input int n);
    int i;
    for (i = 0; i < n; i++)
      @(negedge clk);
  endtask

  // watch the image after cs_n rose, bounded by the commit window
  task automatic wait_commit(input ctrl_regs_t exp, input ctrl_regs_t prev);
    int cycles;
    cycles = 0;
    while (cycles < COMMIT_WINDOW)
    begin
      @(negedge clk);
      cycles++;
      if (regs != prev)
        break;
    end
    if (exp != prev)
    begin
      if (regs == prev)
      begin
        $display("timeout: register image did not change within %0d cycles after cs_n rose",
                 COMMIT_WINDOW);
        $display("Test failures found");
        $fatal(1, "commit never seen");
      end
      check_equal(IMG_BITS'(cycles), IMG_BITS'(COMMIT_LATENCY), "commit latency in cycles");
    end
    check_equal(regs, exp, "register image after frame");
  endtask

  //////////////////////////////////////////////////
  // SPI master, mode 0, msb first

  task automatic spi_frame(
    input  logic [7:0] addr,
    input  logic [7:0] value,
    input  int         nbits,
    output logic [7:0] rd_byte
  );
    logic [16:0] tx_bits;
    logic [7:0]  rx;
    int i;
    tx_bits = {addr, value, 1'b0};   // pad bit for long frames
    rx      = 8'hFF;
    @(negedge clk);
    pins.cs_n = 1'b0;
    pins.mosi = tx_bits[16];
    for (i = 0; i < nbits; i++)
    begin
      hold_cycles(HALF_SCLK);
      // value byte carries the readback
      if (i >= 8 && i < 16)
        rx = {rx[6:0], miso};
      pins.sclk = 1'b1;
      hold_cycles(HALF_SCLK);
      pins.sclk = 1'b0;
      if (i + 1 < nbits)
        pins.mosi = tx_bits[15-i];
    end
    hold_cycles(HALF_SCLK);
    pins.cs_n = 1'b1;
    pins.mosi = 1'b0;
    rd_byte   = rx;
  endtask

  // random peripheral miso against the routing rule
  task automatic check_routing(input logic cs2_level, input logic [NUM_PERIPH-1:0] sel);
    logic [NUM_PERIPH-1:0] pm;
    logic [NUM_PERIPH-1:0] cs_exp;
    int k;
    for (k = 0; k < 6; k++)
    begin
      pm          = NUM_PERIPH'($urandom);
      periph_miso = pm;
      cs2_n       = cs2_level;
      @(posedge clk);
      cs_exp = cs2_level ? '1 : ~sel;
      check_equal(IMG_BITS'(periph_cs_n), IMG_BITS'(cs_exp), "periph_cs_n");
      if (!cs2_level)
        check_equal(IMG_BITS'(miso), IMG_BITS'(|(sel & pm)), "routed miso");
      @(negedge clk);
    end
    cs2_n = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial
  begin
    int         idx;
    logic [7:0] rd_byte;
    entry_t     e;
    ctrl_regs_t prev_img;
    pins        = '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0};
    cs2_n       = 1'b1;
    periph_miso = '0;
    reset       = 1'b1;
    // first draw seeds the generator
    mon_rails   = 4'($urandom(32'h65d9));
    model_regs  = SOFT_RESET_REGS;

    // set, toggle and clear on the led, then a mix with random values
    add_entry(LED, 8'h05, 16, 1'b1);
    add_entry(LED, 8'h33, 16, 1'b1);
    add_entry(LED, 8'h40, 16, 1'b1);
    add_entry(MUX, 8'h0A, 16, 1'b0);
    add_entry(RAILS, 8'($urandom), 16, 1'b1);
    add_entry(DAC, 8'($urandom), 16, 1'b1);
    add_entry(MON_RAILS, 8'($urandom), 16, 1'b1);
    // long then short frame, neither may commit
    // the last 16 bits of either one would hit the led
    // long frame pad bit becomes the stale top bit of the short one
    add_entry(8'h03, 8'h8A, 17, 1'b1);
    add_entry(ADC, 8'h0E, 15, 1'b1);
    add_entry(CMD_POWERUP, 8'h00, 16, 1'b0);
    add_entry(MUX_SEL, 8'($urandom), 16, 1'b1);
    add_entry(INA_VFB_ATTEN_SW, 8'($urandom), 16, 1'b1);
    add_entry(8'd40, 8'h0F, 16, 1'b1);
    add_entry(MUX, 8'($urandom), 16, 1'b0);
    add_entry(LED, 8'($urandom), 16, 1'b1);
    add_entry(CMD_SOFT_RESET, 8'h5A, 16, 1'b0);
    add_entry(IRANGE_YZ_SW, 8'($urandom), 16, 1'b0);

    // reset for three cycles
    for (idx = 0; idx < 3; idx++)
      @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    check_equal(regs, SOFT_RESET_REGS, "image after reset");
    check_equal(IMG_BITS'(periph_cs_n), IMG_BITS'({NUM_PERIPH{1'b1}}), "periph_cs_n after reset");
    check_equal(IMG_BITS'(miso), IMG_BITS'(1'b1), "idle miso after reset");
    check_routing(1'b0, SOFT_RESET_REGS.mux[NUM_PERIPH-1:0]);

    prev_img = SOFT_RESET_REGS;
    for (idx = 0; idx < table_q.size(); idx++)
    begin
      e = table_q[idx];
      spi_frame(e.addr, e.value, int'(e.nbits), rd_byte);
      if (e.nbits >= 5'd16)
        check_equal(IMG_BITS'(rd_byte), IMG_BITS'(e.exp_read), "readback byte");
      wait_commit(e.exp_regs, prev_img);
      check_routing(e.route_cs2_n, e.exp_regs.mux[NUM_PERIPH-1:0]);
      prev_img = e.exp_regs;
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== flist.f ====
hdl/smu_spi_pkg.sv
hdl/smu_reg_pkg.sv
hdl/spi_input_sync.sv
hdl/spi_frame_shifter.sv
hdl/ctrl_reg_file.sv
hdl/periph_spi_router.sv
hdl/smu_ctrl_top.sv
verification/smu_ctrl_tb.sv

// ==== Makefile ====
# Verilator flow for the SMU control bank
# sim exits non-zero when the testbench stops on $fatal

TOP := smu_ctrl_tb

.PHONY: all lint sim clean

all: sim

# static checks on the RTL and the testbench
lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f flist.f

# build the testbench binary and run it
sim:
	verilator --binary --assert --top-module $(TOP) -Mdir obj_dir -o $(TOP) -f flist.f
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
